/* common/ctlb_pkg.sv */
// Shared definitions for the instruction-fetch TLB.
// Virtual fetch addresses are 44 bits and address-space ids are 21 bits,
// so a stored tag is 65 bits with the id above the address.
// The CSR numbers and the VM flag position must match the CSR file of the core.
// The stored entry is a packed struct and its field order is the RAM layout.

package ctlb_pkg;

  // address and id widths
  localparam int va_width = 44;
  localparam int asid_width = 21;
  localparam int ip_width = asid_width + va_width;

  // geometry
  localparam int set_count = 64;
  localparam int set_bits = 6;
  localparam int way_count = 4;

  // offset bits ignored by the compare in each mode
  localparam int page_bits = 13;
  localparam int jump_bits = 4;

  // translation payload
  localparam int data_width = 32;
  localparam int global_bit = 31;

  // CSR numbers seen on the CSR write bus
  localparam logic [15:0] csr_page = 16'h0180;
  localparam logic [15:0] csr_mflags = 16'h0300;

  // machine-flags bit that turns on address-space ids
  localparam int mflags_vm = 2;

  typedef logic [data_width-1:0] ctlb_data_t;

  // one stored word per set and way
  typedef struct packed {
    logic [ip_width-1:0] ip;
    logic valid;
    logic valid_n;
    logic [1:0] age;
    ctlb_data_t data;
  } ctlb_entry_t;

  // top-level sequencer
  typedef enum logic {
    init_sweep,
    run
  } ctlb_state_e;

  // lookup and fill modes
  typedef enum logic {
    mode_normal,
    mode_jump
  } ctlb_mode_e;

endpackage

/* source/csr_watch.sv */
// Shadow copy of one CSR, taken from the CSR write bus.
// The bus has no acknowledge; a write is one cycle of csr_en.
// The copy is valid from the cycle after the write.

module csr_watch #(
  parameter logic [15:0] csr_num = 16'h0000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        csr_en,
  input  logic [15:0] csr_addr,
  input  logic [64:0] csr_data,
  output logic [64:0] value
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      value <= '0;
    end
    else if (csr_en && (csr_addr == csr_num))
    begin
      value <= csr_data;
    end
  end

endmodule

/* ctlb/ctlb_set_ram.sv */
// Storage for one TLB way, one entry per set.
// Read is combinational, write lands on the rising edge.
// Contents are undefined until the init sweep has written every set.

module ctlb_set_ram (
  input  logic                                clk,
  input  logic [ctlb_pkg::set_bits-1:0]       read_addr,
  output ctlb_pkg::ctlb_entry_t               read_data,
  input  logic [ctlb_pkg::set_bits-1:0]       write_addr,
  input  ctlb_pkg::ctlb_entry_t               write_data,
  input  logic                                write_en
);

  ctlb_pkg::ctlb_entry_t mem [ctlb_pkg::set_count];

  assign read_data = mem[read_addr];

  always_ff @(posedge clk)
  begin
    if (write_en)
    begin
      mem[write_addr] <= write_data;
    end
  end

endmodule

/* ctlb/ctlb_lru.sv */
// True-age update for one way of a set.
// access_age is the old age of the accessed way, 3 on a fill.
// Ages of the four ways in a set stay a permutation of 0 to 3.

module ctlb_lru (
  input  logic [1:0] old_age,
  input  logic [1:0] access_age,
  input  logic       access,
  output logic [1:0] new_age
);

  always_comb
  begin
    new_age = old_age;
    if (access)
    begin
      // accessed way becomes youngest
      if (old_age == access_age)
      begin
        new_age = 2'd0;
      end
      // younger than the accessed way ages by one
      else if (old_age < access_age)
      begin
        new_age = old_age + 2'd1;
      end
    end
  end

endmodule

/* ctlb/ctlb_way.sv */
// One way of the fetch TLB with its set RAM.
// Lookup, fill and invalidate all use the same set index, chosen by mode.
// The set is rewritten on every fill and every unstalled lookup so that
// the ages stay consistent across the ways; a miss rewrites the old word.
// way_index seeds the age at init and must be 0 to 3.

module ctlb_way #(
  parameter int way_index = 0
) (
  input  logic                                clk,
  input  logic                                read_en,
  input  logic                                stall,
  input  logic [ctlb_pkg::va_width-1:0]       addr,
  input  ctlb_pkg::ctlb_mode_e                mode,
  input  logic [ctlb_pkg::asid_width-1:0]     asid,
  input  logic                                invalidate,
  input  logic                                write_en,
  input  ctlb_pkg::ctlb_data_t                write_data,
  input  logic                                init,
  input  logic [ctlb_pkg::set_bits-1:0]       init_set,
  input  logic [1:0]                          new_age,
  output logic [1:0]                          age,
  output logic                                hit,
  output ctlb_pkg::ctlb_data_t                data
);

  localparam logic [ctlb_pkg::va_width-1:0] page_mask =
    {{(ctlb_pkg::va_width - ctlb_pkg::page_bits){1'b0}}, {ctlb_pkg::page_bits{1'b1}}};
  localparam logic [ctlb_pkg::va_width-1:0] jump_mask =
    {{(ctlb_pkg::va_width - ctlb_pkg::jump_bits){1'b0}}, {ctlb_pkg::jump_bits{1'b1}}};

  logic [ctlb_pkg::set_bits-1:0] index;
  logic [ctlb_pkg::va_width-1:0] va_mask;
  logic [ctlb_pkg::ip_width-1:0] ip_mask;
  logic [ctlb_pkg::ip_width-1:0] key;
  ctlb_pkg::ctlb_entry_t rd_entry;
  ctlb_pkg::ctlb_entry_t wr_entry;
  logic wr_en;
  logic mode_valid;
  logic own_match;
  logic global_match;
  logic victim;
  logic kill;

  // normal mode indexes by page number, jump mode by bits 9:4
  assign index = init ? init_set :
                 (mode == ctlb_pkg::mode_jump) ? addr[ctlb_pkg::jump_bits +: ctlb_pkg::set_bits] :
                                                 addr[ctlb_pkg::page_bits +: ctlb_pkg::set_bits];

  assign va_mask = (mode == ctlb_pkg::mode_jump) ? jump_mask : page_mask;
  assign ip_mask = {{ctlb_pkg::asid_width{1'b0}}, va_mask};
  assign key = {asid, addr};

  ctlb_set_ram u_ram (
    .clk        (clk),
    .read_addr  (index),
    .read_data  (rd_entry),
    .write_addr (index),
    .write_data (wr_entry),
    .write_en   (wr_en)
  );

  // tag compare with the offset bits forced to one on both sides
  assign mode_valid = (mode == ctlb_pkg::mode_jump) ? rd_entry.valid_n : rd_entry.valid;
  assign own_match = (rd_entry.ip | ip_mask) == (key | ip_mask);
  // global entries ignore the id part of the tag
  assign global_match = rd_entry.data[ctlb_pkg::global_bit] &&
                        ((rd_entry.ip[ctlb_pkg::va_width-1:0] | va_mask) == (addr | va_mask));
  assign hit = mode_valid && (own_match || global_match);

  assign age = rd_entry.age;
  assign data = rd_entry.data;

  assign victim = write_en && (rd_entry.age == 2'd3);
  assign kill = read_en && invalidate && hit;
  assign wr_en = init || write_en || (read_en && !stall);

  always_comb
  begin
    wr_entry = rd_entry;
    wr_entry.age = new_age;
    if (kill)
    begin
      wr_entry.valid = 1'b0;
      wr_entry.valid_n = 1'b0;
    end
    if (init)
    begin
      wr_entry = '0;
      wr_entry.age = 2'(way_index);
    end
    else if (victim)
    begin
      wr_entry.ip = key;
      wr_entry.valid = (mode == ctlb_pkg::mode_normal);
      wr_entry.valid_n = (mode == ctlb_pkg::mode_jump);
      wr_entry.data = write_data;
    end
  end

endmodule

/* ctlb/ctlb.sv */
// Instruction-fetch TLB, 4 ways by 64 sets, lookup result in the same cycle.
// After rst a 64-cycle sweep clears all sets; ready is low until it ends,
// and during that time hits read as zero and fills are dropped.
// stall freezes the side effects of a lookup; fills go ahead regardless.
// write_en and read_en must not be high together.
// At most one way is expected to hit; the page walker guarantees this.

module ctlb (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  logic                                stall,
  input  logic [ctlb_pkg::va_width-1:0]       addr,
  input  logic                                nat_jump,
  input  logic                                invalidate,
  output logic                                read_hit,
  output ctlb_pkg::ctlb_data_t                read_data,
  input  logic                                write_en,
  input  ctlb_pkg::ctlb_data_t                write_data,
  input  logic                                csr_en,
  input  logic [15:0]                         csr_addr,
  input  logic [64:0]                         csr_data,
  output logic                                ready
);

  ctlb_pkg::ctlb_state_e state;
  logic [ctlb_pkg::set_bits-1:0] sweep_count;
  logic init;
  ctlb_pkg::ctlb_mode_e mode;
  logic [64:0] page_value;
  logic [64:0] mflags_value;
  logic [ctlb_pkg::asid_width-1:0] asid;
  logic lookup;
  logic fill;
  logic [ctlb_pkg::way_count-1:0] way_hit;
  logic [ctlb_pkg::way_count-1:0][1:0] old_age;
  logic [ctlb_pkg::way_count-1:0][1:0] new_age;
  ctlb_pkg::ctlb_data_t way_data [ctlb_pkg::way_count];
  logic [1:0] hit_age;
  logic [1:0] access_age;
  logic access;
  ctlb_pkg::ctlb_data_t hit_data;

  // init sweep, one set of every way per cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ctlb_pkg::init_sweep;
      sweep_count <= '0;
    end
    else if (state == ctlb_pkg::init_sweep)
    begin
      sweep_count <= sweep_count + 1'b1;
      if (sweep_count == ctlb_pkg::set_bits'(ctlb_pkg::set_count - 1))
      begin
        state <= ctlb_pkg::run;
      end
    end
  end

  assign init = (state == ctlb_pkg::init_sweep);
  assign ready = (state == ctlb_pkg::run);
  assign mode = nat_jump ? ctlb_pkg::mode_jump : ctlb_pkg::mode_normal;

  csr_watch #(.csr_num(ctlb_pkg::csr_page)) u_page_watch (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (page_value)
  );

  csr_watch #(.csr_num(ctlb_pkg::csr_mflags)) u_mflags_watch (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (mflags_value)
  );

  // id 0 is reserved for the no-VM case, hence the xor
  assign asid = mflags_value[ctlb_pkg::mflags_vm] ?
                (page_value[ctlb_pkg::asid_width-1:0] ^ ctlb_pkg::asid_width'(1)) : '0;

  assign lookup = read_en && ready;
  assign fill = write_en && ready;

  // age of the hit way, zero when nothing hits
  always_comb
  begin
    hit_age = 2'd0;
    hit_data = '0;
    for (int w = 0; w < ctlb_pkg::way_count; w++)
    begin
      if (way_hit[w])
      begin
        hit_age = hit_age | old_age[w];
        hit_data = hit_data | way_data[w];
      end
    end
  end

  // a fill always replaces the oldest way
  assign access_age = fill ? 2'd3 : hit_age;
  assign access = fill || (lookup && (|way_hit));

  for (genvar w = 0; w < ctlb_pkg::way_count; w++)
  begin : g_way
    ctlb_way #(.way_index(w)) u_way (
      .clk        (clk),
      .read_en    (lookup),
      .stall      (stall),
      .addr       (addr),
      .mode       (mode),
      .asid       (asid),
      .invalidate (invalidate),
      .write_en   (fill),
      .write_data (write_data),
      .init       (init),
      .init_set   (sweep_count),
      .new_age    (new_age[w]),
      .age        (old_age[w]),
      .hit        (way_hit[w]),
      .data       (way_data[w])
    );

    ctlb_lru u_lru (
      .old_age    (old_age[w]),
      .access_age (access_age),
      .access     (access),
      .new_age    (new_age[w])
    );
  end

  assign read_hit = ready && (|way_hit);
  assign read_data = read_hit ? hit_data : '0;

endmodule

/* sim/tb_clock.sv */
// Free-running testbench clock with a period of 10 time units.
// Starts low, so the first rising edge is at time 5.

module tb_clock (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

/* sim/ctlb_tb.sv */
// Testbench for the fetch TLB, driven from sim/ctlb_patterns.txt.
// Run from the project root so that the pattern path resolves.
// Inputs change 1 time unit after the rising edge, and lookups are
// checked 2 time units before the next edge.
// Only lookup lines (L, I, S) carry expected hit and data.

module ctlb_tb;

  localparam int reset_cycles = 10;
  localparam int sweep_cycles = 64;
  localparam int ready_timeout = 200;

  logic clk;
  logic rst;
  logic read_en;
  logic stall;
  logic [ctlb_pkg::va_width-1:0] addr;
  logic nat_jump;
  logic invalidate;
  logic read_hit;
  ctlb_pkg::ctlb_data_t read_data;
  logic write_en;
  ctlb_pkg::ctlb_data_t write_data;
  logic csr_en;
  logic [15:0] csr_addr;
  logic [64:0] csr_data;
  logic ready;
  int sweep_len;
  int op_count;

  tb_clock u_clock (
    .clk (clk)
  );

  ctlb u_dut (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .stall      (stall),
    .addr       (addr),
    .nat_jump   (nat_jump),
    .invalidate (invalidate),
    .read_hit   (read_hit),
    .read_data  (read_data),
    .write_en   (write_en),
    .write_data (write_data),
    .csr_en     (csr_en),
    .csr_addr   (csr_addr),
    .csr_data   (csr_data),
    .ready      (ready)
  );

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_hit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("FAILED at time %0t: %s, read_hit %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input ctlb_pkg::ctlb_data_t got, input ctlb_pkg::ctlb_data_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("FAILED at time %0t: %s, read_data %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // idle values for every DUT input except rst
  task automatic clear_inputs();
    read_en = 1'b0;
    stall = 1'b0;
    addr = '0;
    nat_jump = 1'b0;
    invalidate = 1'b0;
    write_en = 1'b0;
    write_data = '0;
    csr_en = 1'b0;
    csr_addr = '0;
    csr_data = '0;
  endtask

  // counts the cycles with ready low and checks that the lookup outputs stay zero
  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (ready !== 1'b1)
    begin
      check_hit(read_hit, 1'b0, "read_hit while ready is low");
      check_data(read_data, '0, "read_data while ready is low");
      cycles++;
      if (cycles > ready_timeout)
      begin
        $display("ready did not rise within %0d cycles after reset", ready_timeout);
        stop_run();
      end
      else
      begin
        @(posedge clk);
        #8;
      end
    end
  endtask

  // one operation per cycle; side effects land on the following edge
  task automatic apply_op(input logic [7:0] op, input logic jump,
                          input logic [ctlb_pkg::va_width-1:0] op_addr, input logic [64:0] op_data,
                          input logic exp_hit, input ctlb_pkg::ctlb_data_t exp_data, input int num);
    string what;
    @(posedge clk);
    #1;
    clear_inputs();
    what = $sformatf("op %0d (%c at %h)", num, op, op_addr);
    if (op == "C")
    begin
      csr_en = 1'b1;
      csr_addr = op_addr[15:0];
      csr_data = op_data;
    end
    else if (op == "F")
    begin
      write_en = 1'b1;
      nat_jump = jump;
      addr = op_addr;
      write_data = op_data[ctlb_pkg::data_width-1:0];
    end
    else
    begin
      read_en = 1'b1;
      nat_jump = jump;
      addr = op_addr;
      invalidate = (op != "L");
      stall = (op == "S");
    end
    #7;
    if (op == "L" || op == "I" || op == "S")
    begin
      check_hit(read_hit, exp_hit, what);
      check_data(read_data, exp_data, what);
    end
  endtask

  task automatic play_patterns(output int count);
    int fd;
    int n;
    int jump_in;
    int hit_in;
    logic [7:0] op;
    logic [ctlb_pkg::va_width-1:0] op_addr;
    logic [64:0] op_data;
    ctlb_pkg::ctlb_data_t exp_data;
    logic [8*256-1:0] rest;
    logic done;
    count = 0;
    done = 1'b0;
    fd = $fopen("sim/ctlb_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file sim/ctlb_patterns.txt");
      stop_run();
    end
    else
    begin
      while (!done)
      begin
        n = $fscanf(fd, " %c", op);
        if (n != 1)
        begin
          done = 1'b1;
        end
        else if (op == "#")
        begin
          // drop the rest of a comment line
          n = $fgets(rest, fd);
        end
        else if (op == "C" || op == "F" || op == "L" || op == "I" || op == "S")
        begin
          n = $fscanf(fd, "%d %h %h %d %h", jump_in, op_addr, op_data, hit_in, exp_data);
          if (n != 5)
          begin
            $display("pattern line after operation %0d has missing fields", count);
            stop_run();
          end
          else
          begin
            count++;
            apply_op(op, jump_in[0], op_addr, op_data, hit_in[0], exp_data, count);
          end
        end
        else
        begin
          $display("unknown operation letter %c in the pattern file", op);
          stop_run();
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    clear_inputs();
    rst = 1'b1;
    for (int i = 0; i < reset_cycles; i++)
    begin
      @(posedge clk);
      #1;
      check_hit(read_hit, 1'b0, "read_hit during reset");
      check_data(read_data, '0, "read_data during reset");
    end
    rst = 1'b0;
    #7;
    wait_ready(sweep_len);
    if (sweep_len != sweep_cycles)
    begin
      $display("FAILED at time %0t: init sweep took %0d cycles, expected %0d",
               $time, sweep_len, sweep_cycles);
      stop_run();
    end
    else
    begin
      play_patterns(op_count);
      // let the last operation reach its edge
      @(posedge clk);
      #1;
      clear_inputs();
      if (op_count == 0)
      begin
        $display("no operations were read from the pattern file");
        stop_run();
      end
      else
      begin
        $display("Regression passed");
        $finish;
      end
    end
  end

endmodule

/* sim/ctlb_patterns.txt */
# op jump addr data hit exp_data   (addr, data and exp_data in hex)
# op: C csr write (addr is the CSR number), F fill, L lookup, I invalidating
#     lookup, S stalled invalidating lookup; hit and exp_data apply to lookups only
# lookups right after init miss
L 0 00000001000 0 0 00000000
L 1 abcdef01230 0 0 00000000
L 0 fffffffffff 0 0 00000000
# normal fill covers its 8 KB page in normal mode only
F 0 00000024120 00001234 0 00000000
L 0 00000025ffc 0 1 00001234
L 0 00000024000 0 1 00001234
L 0 00000026000 0 0 00000000
L 1 00000024120 0 0 00000000
# jump fill compares bits 43:4
F 1 00000abc350 00005678 0 00000000
L 1 00000abc35f 0 1 00005678
L 1 00001abc350 0 0 00000000
L 0 00000abc350 0 0 00000000
# VM flag on, id becomes page xor 1
C 0 00000000300 4 0 00000000
L 0 00000024120 0 0 00000000
C 0 00000000180 155 0 00000000
F 0 00000102000 00000aaa 0 00000000
F 0 00000104000 80000bbb 0 00000000
L 0 00000102000 0 1 00000aaa
L 0 00000104010 0 1 80000bbb
C 0 00000000180 2a0 0 00000000
L 0 00000102000 0 0 00000000
L 0 00000104010 0 1 80000bbb
C 0 00000000300 0 0 00000000
L 0 00000024120 0 1 00001234
L 0 00000102000 0 0 00000000
L 0 00000104010 0 1 80000bbb
# set 5, fifth fill evicts the first
F 0 0000000a000 00000011 0 00000000
F 0 0000008a000 00000012 0 00000000
F 0 0000010a000 00000013 0 00000000
F 0 0000018a000 00000014 0 00000000
F 0 0000020a000 00000015 0 00000000
L 0 0000000a000 0 0 00000000
L 0 0000008a000 0 1 00000012
L 0 0000020a000 0 1 00000015
# set 6, hit on the oldest moves the victim to the second fill
F 0 0000000c000 00000021 0 00000000
F 0 0000008c000 00000022 0 00000000
F 0 0000010c000 00000023 0 00000000
F 0 0000018c000 00000024 0 00000000
L 0 0000000c000 0 1 00000021
F 0 0000020c000 00000025 0 00000000
L 0 0000000c000 0 1 00000021
L 0 0000008c000 0 0 00000000
L 0 0000010c000 0 1 00000023
L 0 0000020c000 0 1 00000025
# set 7, stall keeps the entry, invalidate drops it
F 0 0000000e000 00000077 0 00000000
S 0 0000000e000 0 1 00000077
L 0 0000000e000 0 1 00000077
I 0 0000000e000 0 1 00000077
L 0 0000000e000 0 0 00000000
# set 8, stalled hit on the oldest leaves it as the victim
F 0 00000010000 00000081 0 00000000
F 0 00000090000 00000082 0 00000000
F 0 00000110000 00000083 0 00000000
F 0 00000190000 00000084 0 00000000
S 0 00000010000 0 1 00000081
F 0 00000210000 00000085 0 00000000
L 0 00000010000 0 0 00000000
L 0 00000090000 0 1 00000082
L 0 00000210000 0 1 00000085

/* flist.f */
common/ctlb_pkg.sv
source/csr_watch.sv
ctlb/ctlb_set_ram.sv
ctlb/ctlb_lru.sv
ctlb/ctlb_way.sv
ctlb/ctlb.sv
sim/tb_clock.sv
sim/ctlb_tb.sv

/* Bender.yml */
package:
  name: ctlb

sources:
  - common/ctlb_pkg.sv
  - source/csr_watch.sv
  - ctlb/ctlb_set_ram.sv
  - ctlb/ctlb_lru.sv
  - ctlb/ctlb_way.sv
  - ctlb/ctlb.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/ctlb_tb.sv
